// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exe_stage
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TESTBENCH PASSED

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check:
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== exe_alu.sv ====
// arithmetic and logic unit of the execute stage
`timescale 1ns/1ps
`default_nettype none

module exe_alu
	import exe_ctrl_pkg::*, exe_data_pkg::*;
(
	input  alu_op_e alu_op,
	input  word_t   op_a,
	input  word_t   op_b,
	output word_t   result
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	// shift amount from the low bits only
	assign shamt = op_b[4:0];

	assign lt_s = $signed(op_a) < $signed(op_b);
	assign lt_u = op_a < op_b;

	always_comb begin
		case (alu_op)
			alu_add:
				result = op_a + op_b;
			alu_sub:
				result = op_a - op_b;
			alu_sll:
				result = op_a << shamt;
			alu_slt:
				result = {{(data_w-1){1'b0}}, lt_s};
			alu_sltu:
				result = {{(data_w-1){1'b0}}, lt_u};
			alu_xor:
				result = op_a ^ op_b;
			alu_srl:
				result = op_a >> shamt;
			alu_sra:
				result = word_t'($signed(op_a) >>> shamt);
			alu_or:
				result = op_a | op_b;
			alu_and:
				result = op_a & op_b;
			// lui takes the immediate as is
			alu_pass_b:
				result = op_b;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== exe_branch_unit.sv ====
// branch unit: condition compare, jump handling and address adder
`timescale 1ns/1ps
`default_nettype none

module exe_branch_unit
	import exe_ctrl_pkg::*, exe_data_pkg::*;
(
	input  brnch_cnd_e cnd,
	input  addr_base_e addr_base,
	input  word_t      rs1_val,
	input  word_t      rs2_val,
	input  word_t      pc,
	input  word_t      imm,
	output logic       taken,
	output word_t      addr
);

	logic  eq;
	logic  lt_s;
	logic  lt_u;
	word_t base;

	// ------------------------------------------------------------------
	// condition
	// ------------------------------------------------------------------
	assign eq   = rs1_val == rs2_val;
	assign lt_s = $signed(rs1_val) < $signed(rs2_val);
	assign lt_u = rs1_val < rs2_val;

	always_comb begin
		case (cnd)
			cnd_none:   taken = 1'b0;
			cnd_eq:     taken = eq;
			cnd_ne:     taken = !eq;
			cnd_lt:     taken = lt_s;
			cnd_ge:     taken = !lt_s;
			cnd_ltu:    taken = lt_u;
			cnd_geu:    taken = !lt_u;
			cnd_always: taken = 1'b1;
		endcase
	end

	// ------------------------------------------------------------------
	// address adder
	// ------------------------------------------------------------------
	// branch and jal use pc, jalr and load/store use rs1
	assign base = (addr_base == base_src1) ? rs1_val : pc;
	assign addr = base + imm;

endmodule

`default_nettype wire

// ==== exe_ctrl_pkg.sv ====
// control package: opcode and select enums, decoded execute control struct
`default_nettype none

package exe_ctrl_pkg;

	// ------------------------------------------------------------------
	// operation and condition codes
	// ------------------------------------------------------------------
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_e;

	// always is used for jal and jalr
	typedef enum logic [2:0] {
		cnd_none,
		cnd_eq,
		cnd_ne,
		cnd_lt,
		cnd_ge,
		cnd_ltu,
		cnd_geu,
		cnd_always
	} brnch_cnd_e;

	// ------------------------------------------------------------------
	// datapath selects
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_e;
	typedef enum logic {op_a_reg, op_a_pc} op_a_sel_e;
	typedef enum logic {op_b_reg, op_b_imm} op_b_sel_e;
	typedef enum logic {base_pc, base_src1} addr_base_e;
	typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_req_e;

	// load width and sign, only carried to writeback
	typedef enum logic [2:0] {
		wb_byte   = 3'b000,
		wb_half   = 3'b001,
		wb_word   = 3'b010,
		wb_byte_u = 3'b100,
		wb_half_u = 3'b101,
		wb_bypass = 3'b111
	} wb_sx_e;

	typedef struct packed {
		alu_op_e    alu_op;
		brnch_cnd_e cnd;
		fwd_sel_e   fwd1;
		fwd_sel_e   fwd2;
		op_a_sel_e  op_a;
		op_b_sel_e  op_b;
		addr_base_e addr_base;
		mem_req_e   mem_req;
		wb_sx_e     wb_sx;
		logic       we_reg;
		// pick memory result at writeback
		logic       sel_mem;
	} exe_ctrl_t;

endpackage

`default_nettype wire

// ==== exe_data_pkg.sv ====
// data package: width constant, operand, forwarding and stage output structs
`default_nettype none

package exe_data_pkg;

	localparam int data_w = 32;

	typedef logic [data_w-1:0] word_t;

	// register file and instruction values from decode
	typedef struct packed {
		word_t src1;
		word_t src2;
		word_t pc;
		word_t pc_4;
		word_t imm;
	} exe_src_t;

	// results of the later stages
	typedef struct packed {
		word_t mem_result;
		word_t wb_result;
	} fwd_bus_t;

	// ------------------------------------------------------------------
	// record handed to the memory stage
	// ------------------------------------------------------------------
	typedef struct packed {
		word_t                 alu_result;
		word_t                 addr;
		word_t                 store_data;
		word_t                 pc_4;
		exe_ctrl_pkg::mem_req_e mem_req;
		exe_ctrl_pkg::wb_sx_e   wb_sx;
		logic                  we_reg;
		logic                  sel_mem;
	} exe_out_t;

endpackage

`default_nettype wire

// ==== exe_mem_reg.sv ====
// execute to memory stage register with enable, kill and async reset
`timescale 1ns/1ps
`default_nettype none

module exe_mem_reg
	import exe_ctrl_pkg::*, exe_data_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      enb,
	input  logic      kill,
	input  logic      redirect_in,
	input  exe_ctrl_t ctrl,
	input  word_t     alu_result,
	input  word_t     addr,
	input  word_t     store_data,
	input  word_t     pc_4,
	input  logic      taken,
	output exe_out_t  out,
	output logic      redirect
);

	// bubble: no request, no write, bypass load format
	localparam exe_out_t kill_rec = '{
		alu_result: '0,
		addr:       '0,
		store_data: '0,
		pc_4:       '0,
		mem_req:    mem_none,
		wb_sx:      wb_bypass,
		we_reg:     1'b0,
		sel_mem:    1'b0
	};

	exe_out_t rec_new;

	always_comb begin
		rec_new.alu_result = alu_result;
		rec_new.addr       = addr;
		rec_new.store_data = store_data;
		rec_new.pc_4       = pc_4;
		rec_new.mem_req    = ctrl.mem_req;
		rec_new.wb_sx      = ctrl.wb_sx;
		rec_new.we_reg     = ctrl.we_reg;
		rec_new.sel_mem    = ctrl.sel_mem;
	end

	// kill wins over enb, neither means stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out      <= kill_rec;
			redirect <= 1'b0;
		end else if (kill) begin
			out      <= kill_rec;
			redirect <= 1'b0;
		end else if (enb) begin
			out      <= rec_new;
			redirect <= redirect_in | taken;
		end
	end

endmodule

`default_nettype wire

// ==== exe_operand_sel.sv ====
// operand selector: forwarding muxes and ALU operand selection
`timescale 1ns/1ps
`default_nettype none

module exe_operand_sel
	import exe_ctrl_pkg::*, exe_data_pkg::*;
(
	input  exe_ctrl_t ctrl,
	input  exe_src_t  src,
	input  fwd_bus_t  fwd,
	output word_t     rs1_val,
	output word_t     rs2_val,
	output word_t     op_a,
	output word_t     op_b
);

	// one forwarding mux, used for both sources
	function automatic word_t fwd_pick(input fwd_sel_e sel, input word_t reg_val,
		input fwd_bus_t bus);
		word_t val;
		case (sel)
			fwd_mem: val = bus.mem_result;
			fwd_wb:  val = bus.wb_result;
			default: val = reg_val;
		endcase
		return val;
	endfunction

	// ------------------------------------------------------------------
	// forwarding
	// ------------------------------------------------------------------
	assign rs1_val = fwd_pick(ctrl.fwd1, src.src1, fwd);
	assign rs2_val = fwd_pick(ctrl.fwd2, src.src2, fwd);

	// ------------------------------------------------------------------
	// ALU operands
	// ------------------------------------------------------------------
	// pc as first operand for auipc and link
	assign op_a = (ctrl.op_a == op_a_pc) ? src.pc : rs1_val;
	assign op_b = (ctrl.op_b == op_b_imm) ? src.imm : rs2_val;

endmodule

`default_nettype wire

// ==== exe_stage.sv ====
// execute stage top: operand select, ALU, branch unit and stage register
`timescale 1ns/1ps
`default_nettype none

module exe_stage
	import exe_ctrl_pkg::*, exe_data_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      enb,
	input  logic      kill,
	input  logic      redirect_in,
	input  exe_ctrl_t ctrl,
	input  exe_src_t  src,
	input  fwd_bus_t  fwd,
	output exe_out_t  out,
	output logic      redirect,
	output logic      brnch_taken
);

	word_t rs1_val;
	word_t rs2_val;
	word_t op_a;
	word_t op_b;
	word_t alu_result;
	word_t addr;

	exe_operand_sel u_operand_sel (
		.ctrl    (ctrl),
		.src     (src),
		.fwd     (fwd),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.op_a    (op_a),
		.op_b    (op_b)
	);

	exe_alu u_alu (
		.alu_op (ctrl.alu_op),
		.op_a   (op_a),
		.op_b   (op_b),
		.result (alu_result)
	);

	// taken also goes straight out to the hazard unit
	exe_branch_unit u_branch_unit (
		.cnd       (ctrl.cnd),
		.addr_base (ctrl.addr_base),
		.rs1_val   (rs1_val),
		.rs2_val   (rs2_val),
		.pc        (src.pc),
		.imm       (src.imm),
		.taken     (brnch_taken),
		.addr      (addr)
	);

	// store data is the forwarded rs2
	exe_mem_reg u_mem_reg (
		.clk         (clk),
		.rst_n       (rst_n),
		.enb         (enb),
		.kill        (kill),
		.redirect_in (redirect_in),
		.ctrl        (ctrl),
		.alu_result  (alu_result),
		.addr        (addr),
		.store_data  (rs2_val),
		.pc_4        (src.pc_4),
		.taken       (brnch_taken),
		.out         (out),
		.redirect    (redirect)
	);

endmodule

`default_nettype wire

// ==== sim.f ====
exe_ctrl_pkg.sv
exe_data_pkg.sv
exe_operand_sel.sv
exe_alu.sv
exe_branch_unit.sv
exe_mem_reg.sv
exe_stage.sv
tb_exe_stage.sv

// ==== tb_exe_stage.sv ====
// execute stage testbench with reference model, random stimulus, checker and report
`timescale 1ns/1ps
`default_nettype none

module tb_exe_stage
	import exe_ctrl_pkg::*, exe_data_pkg::*;
();

	logic      clk;
	logic      rst_n;
	logic      enb;
	logic      kill;
	logic      redirect_in;
	exe_ctrl_t ctrl;
	exe_src_t  src;
	fwd_bus_t  fwd;
	exe_out_t  out;
	logic      redirect;
	logic      brnch_taken;

	int        errors = 0;
	int        checks = 0;
	int        tests = 0;
	logic      tests_done = 1'b0;
	logic      reset_fault = 1'b0;
	exe_out_t  exp_out;
	logic      exp_redir;

	exe_stage UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.enb         (enb),
		.kill        (kill),
		.redirect_in (redirect_in),
		.ctrl        (ctrl),
		.src         (src),
		.fwd         (fwd),
		.out         (out),
		.redirect    (redirect),
		.brnch_taken (brnch_taken)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------
	function automatic word_t fwd_value(input fwd_sel_e sel, input word_t reg_val,
		input fwd_bus_t f);
		case (sel)
			fwd_mem: return f.mem_result;
			fwd_wb:  return f.wb_result;
			default: return reg_val;
		endcase
	endfunction

	function automatic logic taken_model(input exe_ctrl_t c, input exe_src_t s,
		input fwd_bus_t f);
		word_t a;
		word_t b;
		a = fwd_value(c.fwd1, s.src1, f);
		b = fwd_value(c.fwd2, s.src2, f);
		case (c.cnd)
			cnd_eq:     return a == b;
			cnd_ne:     return a != b;
			cnd_lt:     return $signed(a) < $signed(b);
			cnd_ge:     return $signed(a) >= $signed(b);
			cnd_ltu:    return a < b;
			cnd_geu:    return a >= b;
			cnd_always: return 1'b1;
			default:    return 1'b0;
		endcase
	endfunction

	function automatic exe_out_t exe_model(input exe_ctrl_t c, input exe_src_t s,
		input fwd_bus_t f, input logic redir_in, output logic redir);
		word_t    a;
		word_t    b;
		word_t    x;
		word_t    y;
		exe_out_t r;
		a = fwd_value(c.fwd1, s.src1, f);
		b = fwd_value(c.fwd2, s.src2, f);
		x = (c.op_a == op_a_pc) ? s.pc : a;
		y = (c.op_b == op_b_imm) ? s.imm : b;
		case (c.alu_op)
			alu_add:    r.alu_result = x + y;
			alu_sub:    r.alu_result = x + ~y + 32'd1;
			alu_sll:    r.alu_result = x << y[4:0];
			// signed less-than from the sign bits first
			alu_slt:    r.alu_result = {31'd0, (x[31] != y[31]) ? x[31] : (x < y)};
			alu_sltu:   r.alu_result = {31'd0, x < y};
			alu_xor:    r.alu_result = x ^ y;
			alu_srl:    r.alu_result = x >> y[4:0];
			// logical shift, then the sign fills the vacated bits
			alu_sra:    r.alu_result = (x >> y[4:0]) | ({32{x[31]}} & ~({32{1'b1}} >> y[4:0]));
			alu_or:     r.alu_result = x | y;
			alu_and:    r.alu_result = x & y;
			alu_pass_b: r.alu_result = y;
			default:    r.alu_result = '0;
		endcase
		r.addr       = ((c.addr_base == base_src1) ? a : s.pc) + s.imm;
		r.store_data = b;
		r.pc_4       = s.pc_4;
		r.mem_req    = c.mem_req;
		r.wb_sx      = c.wb_sx;
		r.we_reg     = c.we_reg;
		r.sel_mem    = c.sel_mem;
		redir        = redir_in | taken_model(c, s, f);
		return r;
	endfunction

	function automatic exe_out_t kill_record();
		exe_out_t r;
		r         = '0;
		r.mem_req = mem_none;
		r.wb_sx   = wb_bypass;
		return r;
	endfunction

	// ------------------------------------------------------------------
	// checker
	// ------------------------------------------------------------------
	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	always @(posedge clk) begin
		if (rst_n === 1'b1) begin
			check_val("brnch_taken", 32'(brnch_taken), 32'(taken_model(ctrl, src, fwd)));
			if (kill) begin
				exp_out   = kill_record();
				exp_redir = 1'b0;
			end else if (enb) begin
				exp_out = exe_model(ctrl, src, fwd, redirect_in, exp_redir);
			end
			#2;
			check_val("out.alu_result", out.alu_result, exp_out.alu_result);
			check_val("out.addr", out.addr, exp_out.addr);
			check_val("out.store_data", out.store_data, exp_out.store_data);
			check_val("out.pc_4", out.pc_4, exp_out.pc_4);
			check_val("out.mem_req", 32'(out.mem_req), 32'(exp_out.mem_req));
			check_val("out.wb_sx", 32'(out.wb_sx), 32'(exp_out.wb_sx));
			check_val("out.we_reg", 32'(out.we_reg), 32'(exp_out.we_reg));
			check_val("out.sel_mem", 32'(out.sel_mem), 32'(exp_out.sel_mem));
			check_val("redirect", 32'(redirect), 32'(exp_redir));
		end else begin
			exp_out   = kill_record();
			exp_redir = 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	task automatic randomize_inputs();
		ctrl.alu_op    = alu_op_e'(4'($urandom_range(0, 10)));
		ctrl.cnd       = brnch_cnd_e'(3'($urandom_range(0, 7)));
		ctrl.fwd1      = fwd_sel_e'(2'($urandom_range(0, 2)));
		ctrl.fwd2      = fwd_sel_e'(2'($urandom_range(0, 2)));
		ctrl.op_a      = op_a_sel_e'(1'($urandom_range(0, 1)));
		ctrl.op_b      = op_b_sel_e'(1'($urandom_range(0, 1)));
		ctrl.addr_base = addr_base_e'(1'($urandom_range(0, 1)));
		ctrl.mem_req   = mem_req_e'(2'($urandom_range(0, 2)));
		case ($urandom_range(0, 5))
			0:       ctrl.wb_sx = wb_byte;
			1:       ctrl.wb_sx = wb_half;
			2:       ctrl.wb_sx = wb_word;
			3:       ctrl.wb_sx = wb_byte_u;
			4:       ctrl.wb_sx = wb_half_u;
			default: ctrl.wb_sx = wb_bypass;
		endcase
		ctrl.we_reg    = 1'($urandom_range(0, 1));
		ctrl.sel_mem   = 1'($urandom_range(0, 1));
		src            = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
		fwd            = {$urandom(), $urandom()};
		redirect_in    = 1'b0;
	endtask

	// n cycles of random inputs
	// modes 0 alu, 1 fwd, 2 branch, 3 hold, 4 kill
	task automatic drive_cycles(input int n, input int mode);
		repeat (n) begin
			@(negedge clk);
			randomize_inputs();
			enb  = (mode != 3);
			kill = 1'b0;
			if (mode == 0) begin
				ctrl.fwd1 = fwd_reg;
				ctrl.fwd2 = fwd_reg;
			end
			if (mode == 2) begin
				redirect_in = ($urandom_range(0, 3) == 0);
				// equal operands now and then for eq and ge
				if ($urandom_range(0, 2) == 0) begin
					src.src2  = src.src1;
					ctrl.fwd2 = ctrl.fwd1;
				end
			end
			if (mode == 4) begin
				enb  = 1'($urandom_range(0, 1));
				kill = ($urandom_range(0, 2) == 0);
			end
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		@(negedge clk);
		enb  = 1'b0;
		kill = 1'b0;
		tests++;
		$display("test %s done, %0d errors", name, errors - err_start);
	endtask

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

	initial begin : stimulus
		int cycles;
		int err_start;
		void'($urandom(27));
		enb         = 1'b0;
		kill        = 1'b0;
		redirect_in = 1'b0;
		ctrl        = '0;
		src         = '0;
		fwd         = '0;
		cycles      = 0;
		while (rst_n !== 1'b1 && cycles < 50) begin
			@(negedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was not released within 50 cycles");
			reset_fault = 1'b1;
		end else begin
			err_start = errors;
			repeat (3) @(negedge clk);
			finish_test("reset", err_start);
			err_start = errors;
			drive_cycles(60, 0);
			finish_test("alu", err_start);
			err_start = errors;
			drive_cycles(60, 1);
			finish_test("forwarding", err_start);
			err_start = errors;
			drive_cycles(80, 2);
			@(negedge clk);
			randomize_inputs();
			ctrl.cnd    = cnd_none;
			redirect_in = 1'b1;
			enb         = 1'b1;
			finish_test("branch", err_start);
			err_start = errors;
			drive_cycles(1, 1);
			drive_cycles(10, 3);
			finish_test("hold", err_start);
			err_start = errors;
			drive_cycles(1, 1);
			@(negedge clk);
			randomize_inputs();
			enb  = 1'b1;
			kill = 1'b1;
			drive_cycles(40, 4);
			finish_test("kill", err_start);
		end
		tests_done = 1'b1;
	end

	// ------------------------------------------------------------------
	// end of run
	// ------------------------------------------------------------------
	initial begin : report
		int cycles;
		cycles = 0;
		while (tests_done !== 1'b1 && cycles < 5000) begin
			@(negedge clk);
			cycles++;
		end
		if (tests_done !== 1'b1)
			$display("tests did not finish within 5000 cycles");
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (tests_done === 1'b1 && !reset_fault && errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
